//--- source/fb_pkg.sv
// Frame buffer command package
`default_nettype none

package fb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int NUM_ROWS        = 16;
    localparam int NUM_COLS        = 320;
    localparam int BYTES_PER_PIXEL = 2;
    localparam int COL_BYTES       = 2;  // Column bytes on the input stream

    localparam int FB_DEPTH = NUM_ROWS * NUM_COLS * BYTES_PER_PIXEL;

    typedef logic [3:0] row_addr_t;
    typedef logic [8:0] col_addr_t;
    typedef logic [0:0] pix_byte_t;  // Byte index within a pixel
    typedef logic [$clog2(FB_DEPTH)-1:0] fb_index_t;

    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
        pix_byte_t pix;
    } fb_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and requests
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [7:0] {
        OP_WRITE_PIXEL = 8'h01,
        OP_FILL_ROW    = 8'h02
    } opcode_t;

    localparam logic [7:0] OP_WRITE_PIXEL_CODE = OP_WRITE_PIXEL;
    localparam logic [7:0] OP_FILL_ROW_CODE    = OP_FILL_ROW;

    // One byte write toward the frame buffer
    typedef struct packed {
        logic       valid;
        fb_addr_t   addr;
        logic [7:0] data;
    } fb_wr_req_t;

endpackage

`default_nettype wire

//--- source/cmd_dispatch.sv
// Command opcode dispatcher
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] byte_in,
    input  logic       byte_valid,
    input  logic       wp_done,
    input  logic       fr_done,
    input  logic       fr_busy,
    output logic       wp_enable,
    output logic       fr_enable,
    output logic       busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_PIXEL,
        ST_FILL_ROW
    } dispatch_state_t;

    dispatch_state_t state;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (byte_valid) begin
                        case (byte_in)
                            fb_pkg::OP_WRITE_PIXEL_CODE: state <= ST_WRITE_PIXEL;
                            fb_pkg::OP_FILL_ROW_CODE:    state <= ST_FILL_ROW;
                            default:                     state <= ST_IDLE;  // Dropped
                        endcase
                    end
                end
                ST_WRITE_PIXEL: begin
                    if (wp_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_FILL_ROW: begin
                    if (fr_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Bytes after the opcode go to the active handler
    assign wp_enable = byte_valid && (state == ST_WRITE_PIXEL);
    assign fr_enable = byte_valid && (state == ST_FILL_ROW);

    // Handler still finishing, host must hold off
    assign busy = wp_done || fr_busy;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    // Host has no flow control, so a strobe while busy would be lost
    a_no_strobe_when_busy: assert property (
        @(posedge clk) disable iff (reset) !(byte_valid && busy)
    );

endmodule

`default_nettype wire

//--- source/cmd_write_pixel.sv
// Write pixel command handler
`timescale 1ns/1ps
`default_nettype none

module cmd_write_pixel (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             byte_in,
    input  logic                   enable,
    output fb_pkg::fb_wr_req_t     wr_req,
    output logic                   done
);

    typedef enum logic [1:0] {
        ST_ROW_CAPTURE,
        ST_COLUMN_CAPTURE,
        ST_PIXEL_BYTES,
        ST_DONE
    } wp_state_t;

    localparam int COL_CNT_W = $clog2(fb_pkg::COL_BYTES);

    wp_state_t                       state;
    fb_pkg::row_addr_t               row;
    logic [fb_pkg::COL_BYTES*8-1:0]  col_bits;     // Full column as sent
    logic [COL_CNT_W-1:0]            col_byte_cnt;
    fb_pkg::pix_byte_t               pix;
    logic                            col_in_range;

    // Wide compare so columns past the address width are caught too
    assign col_in_range = (col_bits < fb_pkg::NUM_COLS);

    ////////////////////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_ROW_CAPTURE;
            col_byte_cnt <= '0;
            pix          <= '0;
            done         <= 1'b0;
            wr_req.valid <= 1'b0;
        end else begin
            wr_req.valid <= 1'b0;  // Single-cycle request
            case (state)
                ST_ROW_CAPTURE: begin
                    if (enable) begin
                        row          <= fb_pkg::row_addr_t'(byte_in);
                        col_byte_cnt <= '0;
                        state        <= ST_COLUMN_CAPTURE;
                    end
                end
                ST_COLUMN_CAPTURE: begin
                    if (enable) begin
                        // Little endian, LSB arrives first
                        col_bits[col_byte_cnt*8 +: 8] <= byte_in;
                        if (col_byte_cnt == COL_CNT_W'(fb_pkg::COL_BYTES - 1)) begin
                            pix   <= fb_pkg::pix_byte_t'(fb_pkg::BYTES_PER_PIXEL - 1);
                            state <= ST_PIXEL_BYTES;
                        end else begin
                            col_byte_cnt <= col_byte_cnt + 1'b1;
                        end
                    end
                end
                ST_PIXEL_BYTES: begin
                    if (enable) begin
                        wr_req.valid    <= col_in_range;  // Bad column writes nothing
                        wr_req.addr.row <= row;
                        wr_req.addr.col <= fb_pkg::col_addr_t'(col_bits);
                        wr_req.addr.pix <= pix;
                        wr_req.data     <= byte_in;
                        if (pix == '0) begin
                            done  <= 1'b1;
                            state <= ST_DONE;
                        end else begin
                            pix <= pix - 1'b1;  // Highest byte index first
                        end
                    end
                end
                ST_DONE: begin
                    done  <= 1'b0;
                    state <= ST_ROW_CAPTURE;
                end
                default: state <= ST_ROW_CAPTURE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    // Relies on host strobe spacing, the arbiter never holds this request
    a_req_single_cycle: assert property (
        @(posedge clk) disable iff (reset) wr_req.valid |=> !wr_req.valid
    );

endmodule

`default_nettype wire

//--- source/cmd_fill_row.sv
// Fill row command handler
`timescale 1ns/1ps
`default_nettype none

module cmd_fill_row (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             byte_in,
    input  logic                   enable,
    input  logic                   grant,
    output fb_pkg::fb_wr_req_t     wr_req,
    output logic                   fr_busy,
    output logic                   done
);

    typedef enum logic [1:0] {
        ST_ROW_CAPTURE,
        ST_COLOR_CAPTURE,
        ST_FILL,
        ST_DONE
    } fr_state_t;

    localparam fb_pkg::pix_byte_t TOP_BYTE =
        fb_pkg::pix_byte_t'(fb_pkg::BYTES_PER_PIXEL - 1);
    localparam fb_pkg::col_addr_t LAST_COL =
        fb_pkg::col_addr_t'(fb_pkg::NUM_COLS - 1);

    fr_state_t                             state;
    fb_pkg::row_addr_t                     row;
    logic [fb_pkg::BYTES_PER_PIXEL*8-1:0]  color;
    fb_pkg::pix_byte_t                     color_idx;
    fb_pkg::col_addr_t                     col_cnt;
    fb_pkg::pix_byte_t                     pix_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Capture and fill FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_ROW_CAPTURE;
            color_idx <= '0;
            col_cnt   <= '0;
            pix_cnt   <= '0;
        end else begin
            case (state)
                ST_ROW_CAPTURE: begin
                    if (enable) begin
                        row       <= fb_pkg::row_addr_t'(byte_in);
                        color_idx <= TOP_BYTE;
                        state     <= ST_COLOR_CAPTURE;
                    end
                end
                ST_COLOR_CAPTURE: begin
                    if (enable) begin
                        color[color_idx*8 +: 8] <= byte_in;  // First byte is highest
                        if (color_idx == '0) begin
                            col_cnt <= '0;
                            pix_cnt <= TOP_BYTE;
                            state   <= ST_FILL;
                        end else begin
                            color_idx <= color_idx - 1'b1;
                        end
                    end
                end
                ST_FILL: begin
                    // Step only when the arbiter takes the write
                    if (grant) begin
                        if (pix_cnt == '0) begin
                            pix_cnt <= TOP_BYTE;
                            if (col_cnt == LAST_COL) begin
                                state <= ST_DONE;
                            end else begin
                                col_cnt <= col_cnt + 1'b1;
                            end
                        end else begin
                            pix_cnt <= pix_cnt - 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    state <= ST_ROW_CAPTURE;
                end
                default: state <= ST_ROW_CAPTURE;
            endcase
        end
    end

    // Request held from counters until granted
    assign wr_req.valid    = (state == ST_FILL);
    assign wr_req.addr.row = row;
    assign wr_req.addr.col = col_cnt;
    assign wr_req.addr.pix = pix_cnt;
    assign wr_req.data     = color[pix_cnt*8 +: 8];

    assign fr_busy = (state == ST_FILL) || (state == ST_DONE);
    assign done    = (state == ST_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    // Waiting request stays put until the arbiter takes it
    a_req_held: assert property (
        @(posedge clk) disable iff (reset)
        wr_req.valid && !grant |=> wr_req.valid && $stable(wr_req.addr)
    );

endmodule

`default_nettype wire

//--- source/fb_arbiter.sv
// Frame buffer port arbiter
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  fb_pkg::fb_wr_req_t  wp_req,
    input  fb_pkg::fb_wr_req_t  fr_req,
    input  logic                rd_req,
    input  fb_pkg::fb_addr_t    rd_addr,
    output logic                fr_grant,
    output logic                rd_grant_q,
    output logic                mem_we,
    output fb_pkg::fb_addr_t    mem_addr,
    output logic [7:0]          mem_wdata
);

    logic rd_grant;

    // Write pixel wins outright, reads take idle cycles only
    assign fr_grant = fr_req.valid && !wp_req.valid;
    assign rd_grant = rd_req && !wp_req.valid && !fr_req.valid
                      && !rd_grant_q;  // Host still holds rd_req in the valid cycle

    always_comb begin
        if (wp_req.valid) begin
            mem_we    = 1'b1;
            mem_addr  = wp_req.addr;
            mem_wdata = wp_req.data;
        end else if (fr_req.valid) begin
            mem_we    = 1'b1;
            mem_addr  = fr_req.addr;
            mem_wdata = fr_req.data;
        end else begin
            mem_we    = 1'b0;
            mem_addr  = rd_addr;
            mem_wdata = fr_req.data;
        end
    end

    // Read data lands one cycle after the grant
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_grant_q <= 1'b0;
        end else begin
            rd_grant_q <= rd_grant;
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0({wp_req.valid, fr_grant, rd_grant})
    );

endmodule

`default_nettype wire

//--- source/frame_buffer.sv
// Frame buffer byte memory
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic              clk,
    input  logic              we,
    input  fb_pkg::fb_addr_t  addr,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata
);

    logic [7:0]        mem [fb_pkg::FB_DEPTH];
    fb_pkg::fb_index_t idx;

    // Row major, then column, then pixel byte
    assign idx = fb_pkg::fb_index_t'(
        (int'(addr.row) * fb_pkg::NUM_COLS + int'(addr.col)) * fb_pkg::BYTES_PER_PIXEL
        + int'(addr.pix));

    always_ff @(posedge clk) begin
        if (we && (int'(idx) < fb_pkg::FB_DEPTH)) begin
            mem[idx] <= wdata;
        end
        if (int'(idx) < fb_pkg::FB_DEPTH) begin
            rdata <= mem[idx];  // Registered read
        end else begin
            rdata <= '0;
        end
    end

endmodule

`default_nettype wire

//--- source/fb_ctrl_top.sv
// Display controller command top
`timescale 1ns/1ps
`default_nettype none

module fb_ctrl_top (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        byte_in,
    input  logic              byte_valid,
    input  logic              rd_req,
    input  fb_pkg::fb_addr_t  rd_addr,
    output logic              busy,
    output logic [7:0]        rd_data,
    output logic              rd_valid
);

    logic               wp_enable;
    logic               fr_enable;
    logic               wp_done;
    logic               fr_done;
    logic               fr_busy;
    logic               fr_grant;
    fb_pkg::fb_wr_req_t wp_req;
    fb_pkg::fb_wr_req_t fr_req;
    logic               mem_we;
    fb_pkg::fb_addr_t   mem_addr;
    logic [7:0]         mem_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Command path
    ////////////////////////////////////////////////////////////////////////////
    cmd_dispatch dispatch_i (
        .clk        (clk),
        .reset      (reset),
        .byte_in    (byte_in),
        .byte_valid (byte_valid),
        .wp_done    (wp_done),
        .fr_done    (fr_done),
        .fr_busy    (fr_busy),
        .wp_enable  (wp_enable),
        .fr_enable  (fr_enable),
        .busy       (busy)
    );

    cmd_write_pixel write_pixel_i (
        .clk     (clk),
        .reset   (reset),
        .byte_in (byte_in),
        .enable  (wp_enable),
        .wr_req  (wp_req),
        .done    (wp_done)
    );

    cmd_fill_row fill_row_i (
        .clk     (clk),
        .reset   (reset),
        .byte_in (byte_in),
        .enable  (fr_enable),
        .grant   (fr_grant),
        .wr_req  (fr_req),
        .fr_busy (fr_busy),
        .done    (fr_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////////////////////////////////////////
    fb_arbiter arbiter_i (
        .clk        (clk),
        .reset      (reset),
        .wp_req     (wp_req),
        .fr_req     (fr_req),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .fr_grant   (fr_grant),
        .rd_grant_q (rd_valid),   // Read data valid with the delayed grant
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    frame_buffer frame_buffer_i (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (rd_data)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 5;  // 10 ns clock
    localparam int RESET_CYCLES   = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;  // Released just after the edge
    end

endmodule

`default_nettype wire

//--- dv/fb_ctrl_tb.sv
// Frame buffer controller testbench
`timescale 1ns/1ps
`default_nettype none

module fb_ctrl_tb;

    localparam int BPP            = fb_pkg::BYTES_PER_PIXEL;
    localparam int FILL_WRITES    = fb_pkg::NUM_COLS * BPP;
    localparam int NUM_FILLS      = fb_pkg::NUM_ROWS + 2;
    localparam int NUM_PIXEL_CMDS = 48;                     // Pixel writes and stray opcodes
    localparam int NUM_READS      = 2 * fb_pkg::FB_DEPTH;   // Upper bound
    localparam int TIMEOUT_CYCLES = NUM_FILLS * (FILL_WRITES + 20) + NUM_PIXEL_CMDS * 16
                                    + NUM_READS * 4 + 1000;

    logic             clk;
    logic             reset;
    logic [7:0]       byte_in;
    logic             byte_valid;
    logic             rd_req;
    fb_pkg::fb_addr_t rd_addr;
    logic             busy;
    logic [7:0]       rd_data;
    logic             rd_valid;

    logic [15:0]      lfsr = 16'd14323;
    logic [7:0]       shadow [fb_pkg::FB_DEPTH];  // Expected frame buffer contents
    logic [7:0]       expected_rd;
    int               reads_issued  = 0;
    int               reads_checked = 0;
    int               cycle_count   = 0;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    fb_ctrl_top fb_ctrl_top_i (
        .clk        (clk),
        .reset      (reset),
        .byte_in    (byte_in),
        .byte_valid (byte_valid),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .busy       (busy),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic mismatch_error(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
        $display("** Error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic fatal_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // One full pixel of random bytes
    function automatic logic [BPP*8-1:0] random_color();
        logic [31:0] r;
        r = random_bits(BPP * 8);
        return r[BPP*8-1:0];
    endfunction

    function automatic int flat_index(input int row, input int col, input int pix);
        return (row * fb_pkg::NUM_COLS + col) * BPP + pix;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // One strobe, then one idle cycle
    task automatic send_byte(input logic [7:0] b);
        while (busy) tick();
        byte_in    = b;
        byte_valid = 1'b1;
        tick();
        byte_valid = 1'b0;
        tick();
    endtask

    task automatic write_pixel(input int row, input logic [15:0] col,
                               input logic [BPP*8-1:0] color);
        send_byte(fb_pkg::OP_WRITE_PIXEL_CODE);
        send_byte(8'(row));
        for (int i = 0; i < fb_pkg::COL_BYTES; i++) send_byte(col[i*8 +: 8]);  // LSB first
        for (int p = BPP - 1; p >= 0; p--) send_byte(color[p*8 +: 8]);
        if (col < fb_pkg::NUM_COLS) begin
            for (int p = 0; p < BPP; p++) shadow[flat_index(row, col, p)] = color[p*8 +: 8];
        end
    endtask

    task automatic fill_row(input int row, input logic [BPP*8-1:0] color);
        send_byte(fb_pkg::OP_FILL_ROW_CODE);
        send_byte(8'(row));
        for (int p = BPP - 1; p >= 0; p--) send_byte(color[p*8 +: 8]);
        for (int c = 0; c < fb_pkg::NUM_COLS; c++) begin
            for (int p = 0; p < BPP; p++) shadow[flat_index(row, c, p)] = color[p*8 +: 8];
        end
    endtask

    // Holds the request until rd_valid, the check itself is a property below
    task automatic read_byte(input int row, input int col, input int pix, output int waited);
        rd_addr.row = fb_pkg::row_addr_t'(row);
        rd_addr.col = fb_pkg::col_addr_t'(col);
        rd_addr.pix = fb_pkg::pix_byte_t'(pix);
        expected_rd = shadow[flat_index(row, col, pix)];
        reads_issued++;
        rd_req = 1'b1;
        waited = 0;
        tick();
        while (!rd_valid) begin
            tick();
            waited++;
        end
        rd_req = 1'b0;
        tick();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    a_rd_data: assert property (
        @(posedge clk) disable iff (reset) rd_valid |-> rd_data === expected_rd
    ) else mismatch_error("rd_data", $sampled(expected_rd), $sampled(rd_data));

    a_rd_needs_req: assert property (
        @(posedge clk) disable iff (reset) rd_valid |-> $past(rd_req)
    ) else fatal_error("rd_valid pulsed with no read request outstanding");

    a_reset_busy: assert property (@(posedge clk) reset |=> !busy)
        else mismatch_error("busy", 16'd0, 16'($sampled(busy)));

    a_reset_rd_valid: assert property (@(posedge clk) reset |=> !rd_valid)
        else mismatch_error("rd_valid", 16'd0, 16'($sampled(rd_valid)));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset && rd_valid) reads_checked <= reads_checked + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fatal_error($sformatf("Timeout, run did not end within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int                 row;
        int                 col;
        int                 waited;

        byte_in    = '0;
        byte_valid = 1'b0;
        rd_req     = 1'b0;
        rd_addr    = '0;
        @(negedge reset);
        tick();

        // Whole buffer gets a known value first
        for (int r = 0; r < fb_pkg::NUM_ROWS; r++) fill_row(r, random_color());

        // Fill one row, read it all back plus some neighbors
        row = int'(random_bits(4));
        fill_row(row, random_color());
        for (int c = 0; c < fb_pkg::NUM_COLS; c++) begin
            for (int p = 0; p < BPP; p++) read_byte(row, c, p, waited);
        end
        for (int i = 0; i < 8; i++) begin
            col = int'(random_bits(9)) % fb_pkg::NUM_COLS;
            read_byte((row + 1) % fb_pkg::NUM_ROWS, col, int'(random_bits(1)), waited);
            read_byte((row + fb_pkg::NUM_ROWS - 1) % fb_pkg::NUM_ROWS, col, 0, waited);
        end

        // Random pixels
        for (int i = 0; i < 24; i++) begin
            row = int'(random_bits(4));
            col = int'(random_bits(9)) % fb_pkg::NUM_COLS;
            write_pixel(row, 16'(col), random_color());
            for (int p = BPP - 1; p >= 0; p--) read_byte(row, col, p, waited);
        end

        // Columns above 255 and their low byte aliases
        for (int i = 0; i < 6; i++) begin
            row = int'(random_bits(4));
            col = int'(random_bits(6));
            write_pixel(row, 16'(256 + col), random_color());
            for (int p = 0; p < BPP; p++) begin
                read_byte(row, 256 + col, p, waited);
                read_byte(row, col, p, waited);
            end
        end

        // Read issued while a fill runs
        row = int'(random_bits(4));
        fill_row(row, random_color());
        assert (busy === 1'b1) else mismatch_error("busy", 16'd1, 16'(busy));
        col = int'(random_bits(9)) % fb_pkg::NUM_COLS;
        read_byte(row, col, int'(random_bits(1)), waited);
        assert (waited >= FILL_WRITES - 2)
            else fatal_error($sformatf("Read during fill returned after %0d cycles", waited));
        assert (busy === 1'b0) else mismatch_error("busy", 16'd0, 16'(busy));

        // Out of range columns and unknown opcodes
        row = int'(random_bits(4)) % (fb_pkg::NUM_ROWS - 1);
        write_pixel(row, 16'd320, random_color());
        write_pixel(row, 16'h023F, random_color());
        write_pixel(row, 16'hFFFF, random_color());
        send_byte(8'h00);
        send_byte(8'h03);
        send_byte(8'hFF);
        for (int p = 0; p < BPP; p++) begin
            read_byte(row, 63, p, waited);
            read_byte(row + 1, 0, p, waited);
            read_byte(row + 1, 191, p, waited);
        end
        col = int'(random_bits(9)) % fb_pkg::NUM_COLS;
        write_pixel(row, 16'(col), random_color());  // Dispatcher still alive
        for (int p = 0; p < BPP; p++) read_byte(row, col, p, waited);

        // Final sweep of every byte
        for (int r = 0; r < fb_pkg::NUM_ROWS; r++) begin
            for (int c = 0; c < fb_pkg::NUM_COLS; c++) begin
                for (int p = 0; p < BPP; p++) read_byte(r, c, p, waited);
            end
        end

        if (reads_issued > 0 && reads_checked == reads_issued) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d reads returned data", reads_checked, reads_issued);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- all.f
source/fb_pkg.sv
source/cmd_dispatch.sv
source/cmd_write_pixel.sv
source/cmd_fill_row.sv
source/fb_arbiter.sv
source/frame_buffer.sv
source/fb_ctrl_top.sv
dv/tb_clock_gen.sv
dv/fb_ctrl_tb.sv
